//--- common/support_pkg.sv
// Support package with sequencer state encodings and the flags of the clock domain handshake
`default_nettype none

package support_pkg;

   // Memory controller reset holdoff after dcm_reset, in sysclk cycles
   localparam int holdoff_cycles = 15;

   ////////////////////
   // State encodings

   typedef enum logic [2:0] {
      rs_init   = 3'd0,
      rs_reset1 = 3'd1,
      rs_reset2 = 3'd2,
      rs_reset3 = 3'd3,
      rs_reset4 = 3'd4,
      rs_wait   = 3'd5,
      rs_idle   = 3'd6
   } reset_state_e;

   typedef enum logic [2:0] {
      cs_init   = 3'd0,
      cs_reset1 = 3'd1,
      cs_reset2 = 3'd2,
      cs_reset3 = 3'd3,
      cs_boot   = 3'd4,
      cs_wait   = 3'd5,
      cs_idle   = 3'd6
   } cpu_state_e;

   ////////////////////
   // Handshake flags

   // Levels from the system sequencer, sampled by two flops on cpu_clk
   typedef struct packed {
      logic hold_reset;
      logic start;
      logic sys_idle;
   } sys_to_cpu_t;

   // Acknowledge from the CPU sequencer, sampled by two flops on sysclk
   typedef struct packed {
      logic started;
   } cpu_to_sys_t;

   function automatic sys_to_cpu_t sys_flags(input reset_state_e st);
      sys_to_cpu_t f;
      f.hold_reset = (st inside {rs_init, rs_reset1, rs_reset2, rs_reset3});
      f.start      = (st == rs_reset4);
      f.sys_idle   = (st == rs_idle);
      return f;
   endfunction

   function automatic cpu_to_sys_t cpu_flags(input cpu_state_e st);
      cpu_to_sys_t f;
      f.started = (st inside {cs_reset1, cs_reset2, cs_reset3, cs_boot, cs_wait});
      return f;
   endfunction

endpackage

`default_nettype wire

//--- hdl/button_debounce.sv
// Button debounce, samples the reset button on slow ticks and gives one pulse per press
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
   parameter int press_depth = 10
) (
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic sample_tick,
   input  logic button,
   output logic press
);

   logic                   button_m;
   logic                   button_s;
   logic [press_depth-1:0] history;
   logic                   held;
   logic                   held_q;

   // The button pin is asynchronous to sysclk
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         button_m <= 1'b0;
         button_s <= 1'b0;
      end else begin
         button_m <= button;
         button_s <= button_m;
      end
   end

   ////////////////////
   // Sample history

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         history <= '0;
      end else if (sample_tick) begin
         history <= (history << 1) | press_depth'(button_s);
      end
   end

   // Held once every sample in the window saw the button down
   assign held = &history;

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         held_q <= 1'b0;
      end else begin
         held_q <= held;
      end
   end

   assign press = held & ~held_q;

   a_press_single: assert property (@(posedge sysclk) disable iff (dcm_reset)
      press |=> !press);

endmodule

`default_nettype wire

//--- hdl/support_top.sv
// Board support top level, ties tick dividers, button debounce and both reset sequencers together
`timescale 1ns/1ps
`default_nettype none

module support_top import support_pkg::*; #(
   parameter int med_div     = 64,
   parameter int slow_div    = 4096,
   parameter int cpu_div     = 4,
   parameter int press_depth = 10
) (
   input  logic         sysclk,
   input  logic         cpu_clk,
   input  logic         dcm_reset,
   input  logic         button_r,
   input  logic         lpddr_calib_done,
   output logic         cpu_reset,
   output logic         boot,
   output logic         lpddr_reset,
   output reset_state_e rst_st,
   output cpu_state_e   cpu_st
);

   logic        med_tick;
   logic        slow_tick;
   logic        cpu_tick;
   logic        press;
   sys_to_cpu_t sys_to_cpu;
   cpu_to_sys_t cpu_to_sys;

   ////////////////////
   // Strobes

   tick_divider #(.period(med_div)) u_med_div (
      .clk       (sysclk),
      .dcm_reset (dcm_reset),
      .tick      (med_tick)
   );

   tick_divider #(.period(slow_div)) u_slow_div (
      .clk       (sysclk),
      .dcm_reset (dcm_reset),
      .tick      (slow_tick)
   );

   tick_divider #(.period(cpu_div)) u_cpu_div (
      .clk       (cpu_clk),
      .dcm_reset (dcm_reset),
      .tick      (cpu_tick)
   );

   button_debounce #(.press_depth(press_depth)) u_debounce (
      .sysclk      (sysclk),
      .dcm_reset   (dcm_reset),
      .sample_tick (slow_tick),
      .button      (button_r),
      .press       (press)
   );

   ////////////////////
   // Sequencers

   reset_sequencer u_reset_seq (
      .sysclk           (sysclk),
      .dcm_reset        (dcm_reset),
      .med_tick         (med_tick),
      .press            (press),
      .lpddr_calib_done (lpddr_calib_done),
      .from_cpu         (cpu_to_sys),
      .to_cpu           (sys_to_cpu),
      .lpddr_reset      (lpddr_reset),
      .rst_st           (rst_st)
   );

   cpu_sequencer u_cpu_seq (
      .cpu_clk   (cpu_clk),
      .dcm_reset (dcm_reset),
      .cpu_tick  (cpu_tick),
      .from_sys  (sys_to_cpu),
      .to_sys    (cpu_to_sys),
      .cpu_reset (cpu_reset),
      .boot      (boot),
      .cpu_st    (cpu_st)
   );

endmodule

`default_nettype wire

//--- hdl/tick_divider.sv
// Tick divider, a free-running counter that strobes once per period
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
   parameter int period = 4
) (
   input  logic clk,
   input  logic dcm_reset,
   output logic tick
);

   localparam int cnt_w = (period > 1) ? $clog2(period) : 1;

   logic [cnt_w-1:0] cnt;

   // Strobe sits on the last count of each period
   assign tick = (cnt == cnt_w'(period - 1));

   always_ff @(posedge clk or posedge dcm_reset) begin
      if (dcm_reset) begin
         cnt <= '0;
      end else if (tick) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + cnt_w'(1);
      end
   end

endmodule

`default_nettype wire

//--- reset_seq/cpu_sequencer.sv
// CPU reset sequencer that drives CPU reset and boot and acknowledges the start request
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer import support_pkg::*; (
   input  logic        cpu_clk,
   input  logic        dcm_reset,
   input  logic        cpu_tick,
   input  sys_to_cpu_t from_sys,
   output cpu_to_sys_t to_sys,
   output logic        cpu_reset,
   output logic        boot,
   output cpu_state_e  cpu_st
);

   sys_to_cpu_t from_sys_m;
   sys_to_cpu_t from_sys_s;
   cpu_state_e  cpu_next;

   ////////////////////
   // Synchronizer

   always_ff @(posedge cpu_clk or posedge dcm_reset) begin
      if (dcm_reset) begin
         from_sys_m <= '0;
         from_sys_s <= '0;
      end else begin
         from_sys_m <= from_sys;
         from_sys_s <= from_sys_m;
      end
   end

   ////////////////////
   // State machine

   always_comb begin
      cpu_next = cpu_st;
      case (cpu_st)
         cs_init, cs_idle: begin
            if (from_sys_s.start) begin
               cpu_next = cs_reset1;
            end
         end
         cs_reset1: cpu_next = cs_reset2;
         cs_reset2: cpu_next = cs_reset3;
         cs_reset3: cpu_next = cs_boot;
         cs_boot:   cpu_next = cs_wait;
         cs_wait: begin
            // Started stays up until the system side reports idle
            if (from_sys_s.sys_idle) begin
               cpu_next = cs_idle;
            end
         end
         default:   cpu_next = cs_init;
      endcase
   end

   always_ff @(posedge cpu_clk or posedge dcm_reset) begin
      if (dcm_reset) begin
         cpu_st <= cs_init;
         to_sys <= cpu_flags(cs_init);
      end else if (cpu_tick) begin
         cpu_st <= cpu_next;
         to_sys <= cpu_flags(cpu_next);
      end
   end

   ////////////////////
   // Outputs

   // The system side can hold the CPU in reset on its own
   assign cpu_reset = from_sys_s.hold_reset ||
                      (cpu_st inside {cs_init, cs_reset1, cs_reset2, cs_reset3});

   assign boot = (cpu_st == cs_reset3) || (cpu_st == cs_boot);

   // A new start request only arrives after the last acknowledge has cleared
   a_request_after_release: assert property (@(posedge cpu_clk) disable iff (dcm_reset)
      $rose(from_sys_s.start) |-> !to_sys.started);

endmodule

`default_nettype wire

//--- reset_seq/reset_sequencer.sv
// System reset sequencer that runs memory reset, calibration wait and the CPU start handshake
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer import support_pkg::*; (
   input  logic         sysclk,
   input  logic         dcm_reset,
   input  logic         med_tick,
   input  logic         press,
   input  logic         lpddr_calib_done,
   input  cpu_to_sys_t  from_cpu,
   output sys_to_cpu_t  to_cpu,
   output logic         lpddr_reset,
   output reset_state_e rst_st
);

   localparam int hold_w = $clog2(holdoff_cycles + 1);

   logic              calib_m;
   logic              calib_s;
   cpu_to_sys_t       from_cpu_m;
   cpu_to_sys_t       from_cpu_s;
   logic              press_pend;
   logic              pressed;
   logic [hold_w-1:0] holdoff_cnt;
   logic              holdoff_done;
   reset_state_e      rst_next;

   ////////////////////
   // Synchronizers

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         calib_m    <= 1'b0;
         calib_s    <= 1'b0;
         from_cpu_m <= '0;
         from_cpu_s <= '0;
      end else begin
         calib_m    <= lpddr_calib_done;
         calib_s    <= calib_m;
         from_cpu_m <= from_cpu;
         from_cpu_s <= from_cpu_m;
      end
   end

   // A press between med ticks waits here for the next tick
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         press_pend <= 1'b0;
      end else if (med_tick) begin
         press_pend <= 1'b0;
      end else if (press) begin
         press_pend <= 1'b1;
      end
   end

   assign pressed = press | press_pend;

   ////////////////////
   // Memory reset

   assign holdoff_done = (holdoff_cnt == hold_w'(holdoff_cycles));

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         holdoff_cnt <= '0;
      end else if (!holdoff_done) begin
         holdoff_cnt <= holdoff_cnt + hold_w'(1);
      end
   end

   assign lpddr_reset = holdoff_done && (rst_st == rs_init || rst_st == rs_reset1);

   ////////////////////
   // State machine

   always_comb begin
      rst_next = rst_st;
      case (rst_st)
         rs_init:   rst_next = rs_reset1;
         rs_reset1: rst_next = rs_reset2;
         rs_reset2: rst_next = rs_reset3;
         rs_reset3: begin
            // A new request also waits for the last acknowledge to clear
            if (calib_s && !from_cpu_s.started) begin
               rst_next = rs_reset4;
            end
         end
         rs_reset4: begin
            if (from_cpu_s.started) begin
               rst_next = rs_wait;
            end
         end
         rs_wait: begin
            if (!pressed) begin
               rst_next = rs_idle;
            end
         end
         rs_idle: begin
            if (pressed) begin
               rst_next = rs_reset1;
            end
         end
         default:   rst_next = rs_init;
      endcase
   end

   // Flags are registered with the state so the crossing sees clean levels
   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         rst_st <= rs_init;
         to_cpu <= sys_flags(rs_init);
      end else if (med_tick) begin
         rst_st <= rst_next;
         to_cpu <= sys_flags(rst_next);
      end
   end

   // The CPU side only acknowledges a request that is up
   a_ack_on_request: assert property (@(posedge sysclk) disable iff (dcm_reset)
      $rose(from_cpu_s.started) |-> rst_st == rs_reset4);

   // The acknowledge only drops once the system side has reached idle
   a_ack_release: assert property (@(posedge sysclk) disable iff (dcm_reset)
      $fell(from_cpu_s.started) |-> rst_st inside {rs_idle, rs_reset1, rs_reset2, rs_reset3});

endmodule

`default_nettype wire

//--- tests/tb_support_ref.svh
// Reference rules for the board support testbench, legal state steps and expected output levels
`ifndef tb_support_ref_svh
`define tb_support_ref_svh

// System sequencer steps, one state forward per med tick
function automatic bit rs_legal_next(input reset_state_e from_st, input reset_state_e to_st);
   case (from_st)
      rs_init:   return to_st == rs_reset1;
      rs_reset1: return to_st == rs_reset2;
      rs_reset2: return to_st == rs_reset3;
      rs_reset3: return to_st == rs_reset4;
      rs_reset4: return to_st == rs_wait;
      rs_wait:   return to_st == rs_idle;
      rs_idle:   return to_st == rs_reset1;
      default:   return 1'b0;
   endcase
endfunction

// CPU sequencer steps, a start request leaves init or idle
function automatic bit cs_legal_next(input cpu_state_e from_st, input cpu_state_e to_st);
   case (from_st)
      cs_init:   return to_st == cs_reset1;
      cs_idle:   return to_st == cs_reset1;
      cs_reset1: return to_st == cs_reset2;
      cs_reset2: return to_st == cs_reset3;
      cs_reset3: return to_st == cs_boot;
      cs_boot:   return to_st == cs_wait;
      cs_wait:   return to_st == cs_idle;
      default:   return 1'b0;
   endcase
endfunction

function automatic bit rs_holds(input reset_state_e rs);
   return rs == rs_init || rs == rs_reset1 || rs == rs_reset2 || rs == rs_reset3;
endfunction

function automatic bit exp_boot(input cpu_state_e cs);
   return cs == cs_reset3 || cs == cs_boot;
endfunction

function automatic bit exp_cpu_reset(input reset_state_e rs, input cpu_state_e cs);
   return rs_holds(rs) || cs == cs_init || cs == cs_reset1 || cs == cs_reset2 ||
          cs == cs_reset3;
endfunction

// Memory reset only after the holdoff and only early in the system sequence
function automatic bit exp_lpddr(input int cycles, input reset_state_e rs);
   return cycles >= holdoff_cycles && (rs == rs_init || rs == rs_reset1);
endfunction

`endif

//--- tests/tb_support.sv
// Testbench for the board support top level, runs boot, calibration, glitch and press scenarios
`timescale 1ns/1ps
`default_nettype none

module tb_support import support_pkg::*; ();

   localparam int med_div     = 4;
   localparam int slow_div    = 8;
   localparam int cpu_div     = 4;
   localparam int press_depth = 4;
   localparam int sys_period  = 40;
   localparam int cpu_period  = 56;
   localparam int sync_window = 3 * cpu_period;
   localparam int boot_len    = 2 * cpu_div * cpu_period;
   localparam int wait_limit  = 60 * med_div;
   localparam int run_ticks   = 10 + 50 + 40 + 100 + 120;
   localparam int watchdog_ns = run_ticks * med_div * sys_period * 2;
   localparam int k_state     = 0;
   localparam int k_level     = 1;
   localparam int k_flow      = 2;

   logic         sysclk;
   logic         cpu_clk;
   logic         dcm_reset;
   logic         button_r;
   logic         lpddr_calib_done;
   logic         cpu_reset;
   logic         boot;
   logic         lpddr_reset;
   reset_state_e rst_st;
   cpu_state_e   cpu_st;

   reset_state_e rs_prev = rs_init;
   cpu_state_e   cs_prev = cs_init;
   int           err_cnt [3] = '{0, 0, 0};
   int           sys_cycles = 0;
   int           boot_rises = 0;
   int           cpu_reset_rises = 0;
   int           cpu_reset_falls = 0;
   int           boots_before;
   int           rises_before;
   int           glitch_len;
   integer       seed = 32'hda37;
   time          hold_change_t = 0;
   time          boot_rise_t = 0;
   time          cpu_reset_fall_t = 0;
   time          boot_w;

   `include "tb_support_ref.svh"

   support_top #(
      .med_div     (med_div),
      .slow_div    (slow_div),
      .cpu_div     (cpu_div),
      .press_depth (press_depth)
   ) UUT (
      .sysclk           (sysclk),
      .cpu_clk          (cpu_clk),
      .dcm_reset        (dcm_reset),
      .button_r         (button_r),
      .lpddr_calib_done (lpddr_calib_done),
      .cpu_reset        (cpu_reset),
      .boot             (boot),
      .lpddr_reset      (lpddr_reset),
      .rst_st           (rst_st),
      .cpu_st           (cpu_st)
   );

   initial begin
      sysclk = 1'b0;
      forever #(sys_period / 2) sysclk = ~sysclk;
   end

   // Odd phase offset keeps cpu_clk edges apart from sysclk edges
   initial begin
      cpu_clk = 1'b0;
      #7;
      forever #(cpu_period / 2) cpu_clk = ~cpu_clk;
   end

   task automatic count_error(input int kind, input string msg);
      err_cnt[kind]++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   task automatic wait_sys_cycles(input int n);
      repeat (n) @(negedge sysclk);
   endtask

   task automatic hold_button(input int cycles);
      button_r = 1'b1;
      wait_sys_cycles(cycles);
      button_r = 1'b0;
   endtask

   // Waits for one more boot pulse and both sequencers back in idle
   task automatic finish_reboot(input string what, input int boots_prior);
      int n;
      n = 0;
      while (!(boot_rises > boots_prior && !boot && rst_st == rs_idle && cpu_st == cs_idle)
             && n < wait_limit) begin
         @(negedge sysclk);
         n++;
      end
      if (n >= wait_limit) begin
         err_cnt[k_flow]++;
         $display("%s did not return to idle within %0d sysclk cycles", what, wait_limit);
      end else begin
         assert (boot_rises == boots_prior + 1) else
            count_error(k_flow, $sformatf("%s gave %0d boot pulses", what,
                                          boot_rises - boots_prior));
         assert (cpu_reset === 1'b0 && cpu_reset_fall_t > boot_rise_t) else
            count_error(k_flow, $sformatf("%s did not release cpu_reset during boot", what));
      end
   endtask

   ////////////////////
   // Monitors

   always @(posedge sysclk) begin
      if (!dcm_reset) begin
         sys_cycles <= sys_cycles + 1;
      end
   end

   always @(posedge boot) begin
      if (!dcm_reset) begin
         boot_rises++;
         boot_rise_t = $time;
      end
   end

   always @(negedge boot) begin
      if (!dcm_reset && boot_rises > 0) begin
         boot_w = $time - boot_rise_t;
         assert (boot_w == boot_len) else
            count_error(k_level, $sformatf("boot pulse lasted %0t ns", boot_w));
      end
   end

   always @(posedge cpu_reset) begin
      if (!dcm_reset) begin
         cpu_reset_rises++;
      end
   end

   always @(negedge cpu_reset) begin
      if (!dcm_reset) begin
         cpu_reset_falls++;
         cpu_reset_fall_t = $time;
      end
   end

   ////////////////////
   // Compare

   always @(rst_st or cpu_st) begin
      if (!dcm_reset && rst_st !== rs_prev) begin
         assert (rs_legal_next(rs_prev, rst_st)) else
            count_error(k_state, $sformatf("system step %s to %s", rs_prev.name(), rst_st.name()));
      end
      if (!dcm_reset && cpu_st !== cs_prev) begin
         assert (cs_legal_next(cs_prev, cpu_st)) else
            count_error(k_state, $sformatf("CPU step %s to %s", cs_prev.name(), cpu_st.name()));
      end
      if (rs_holds(rst_st) != rs_holds(rs_prev)) begin
         hold_change_t = $time;
      end
      rs_prev = rst_st;
      cs_prev = cpu_st;
   end

   always @(negedge cpu_clk) begin
      if (!dcm_reset) begin
         assert (boot === exp_boot(cpu_st)) else
            count_error(k_level, $sformatf("boot is %b in %s", boot, cpu_st.name()));
         if ($time - hold_change_t > sync_window) begin
            assert (cpu_reset === exp_cpu_reset(rst_st, cpu_st)) else
               count_error(k_level, $sformatf("cpu_reset is %b in %s and %s", cpu_reset,
                                              rst_st.name(), cpu_st.name()));
         end else begin
            // Hold level still crossing, only the CPU state part is certain
            assert (cpu_reset === 1'b1 || !exp_cpu_reset(rs_idle, cpu_st)) else
               count_error(k_level, $sformatf("cpu_reset low in %s", cpu_st.name()));
         end
      end
   end

   always @(negedge sysclk) begin
      if (!dcm_reset) begin
         assert (lpddr_reset === exp_lpddr(sys_cycles, rst_st)) else
            count_error(k_level, $sformatf("lpddr_reset is %b after %0d cycles in %s",
                                           lpddr_reset, sys_cycles, rst_st.name()));
      end
   end

   ////////////////////
   // Scenarios

   initial begin
      dcm_reset = 1'b1;
      button_r = 1'b0;
      lpddr_calib_done = 1'b0;
      repeat (5) @(negedge sysclk);
      dcm_reset = 1'b0;
      assert (cpu_reset === 1'b1 && boot === 1'b0) else
         count_error(k_flow, "cpu_reset or boot wrong after reset");

      // Calibration stays low
      wait_sys_cycles(50 * med_div);
      assert (rst_st == rs_reset3 && cpu_reset === 1'b1) else
         count_error(k_flow, $sformatf("without calibration state is %s", rst_st.name()));
      assert (boot_rises == 0 && cpu_reset_falls == 0) else
         count_error(k_flow, "boot or cpu_reset moved without calibration");

      lpddr_calib_done = 1'b1;
      finish_reboot("first boot", 0);

      // Short glitches must not reach the sequencers
      rises_before = cpu_reset_rises;
      boots_before = boot_rises;
      for (int i = 0; i < 4; i++) begin
         glitch_len = 1 + ($unsigned($random(seed)) % ((press_depth - 1) * slow_div));
         hold_button(glitch_len);
         wait_sys_cycles(2 * slow_div);
      end
      wait_sys_cycles(10 * med_div);
      assert (cpu_reset_rises == rises_before && boot_rises == boots_before &&
              rst_st == rs_idle) else
         count_error(k_flow, "button glitch started a reboot");

      hold_button((press_depth + 2) * slow_div);
      finish_reboot("button press", boots_before);
      assert (cpu_reset_rises > rises_before) else
         count_error(k_flow, "button press did not raise cpu_reset");

      // A long hold reboots once, the next reboot needs a new press
      boots_before = boot_rises;
      button_r = 1'b1;
      finish_reboot("held button", boots_before);
      wait_sys_cycles(4 * press_depth * slow_div);
      assert (boot_rises == boots_before + 1 && rst_st == rs_idle) else
         count_error(k_flow, "held button rebooted more than once");
      button_r = 1'b0;
      wait_sys_cycles(2 * press_depth * slow_div);
      assert (boot_rises == boots_before + 1) else
         count_error(k_flow, "button release caused a reboot");
      hold_button((press_depth + 2) * slow_div);
      finish_reboot("second press", boots_before + 1);

      $display("state errors %0d, level errors %0d, sequence errors %0d",
               err_cnt[k_state], err_cnt[k_level], err_cnt[k_flow]);
      if (err_cnt[k_state] + err_cnt[k_level] + err_cnt[k_flow] == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("The run timed out after %0d ns", watchdog_ns);
      $display("state errors %0d, level errors %0d, sequence errors %0d",
               err_cnt[k_state], err_cnt[k_level], err_cnt[k_flow]);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
common/support_pkg.sv
hdl/tick_divider.sv
hdl/button_debounce.sv
reset_seq/reset_sequencer.sv
reset_seq/cpu_sequencer.sv
hdl/support_top.sv
tests/tb_support.sv
